// ==== design/decode_stage.sv ====
`timescale 1ns/1ps
`include "mips_defs.svh"

module decode_stage import mips_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  inst_t     dec_inst_i,
    output reg_addr_t rs_addr_o,
    output reg_addr_t rt_addr_o,
    input  word_t     rs_data_i,
    input  word_t     rt_data_i,
    input  logic      ex_byp_en_i,
    input  reg_addr_t ex_byp_reg_i,
    input  word_t     ex_byp_val_i,
    input  logic      res_byp_en_i,
    input  reg_addr_t res_byp_reg_i,
    input  word_t     res_byp_val_i,
    output logic      stall_o,
    pipe_ex_if.source ex_o
);

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    logic [15:0] imm;

    alu_op_e   alu_op;
    mem_op_e   mem_op;
    reg_addr_t dest;
    logic      wr_en;
    logic      use_rs;
    logic      use_rt;
    logic      b_is_imm;
    word_t     imm_val;
    word_t     rs_fwd;
    word_t     rt_fwd;

    // youngest producer wins
    function automatic word_t fwd_operand(input reg_addr_t src, input word_t rf_val);
        if (ex_byp_en_i && ex_byp_reg_i == src) begin
            return ex_byp_val_i;
        end else if (res_byp_en_i && res_byp_reg_i == src) begin
            return res_byp_val_i;
        end else begin
            return rf_val;
        end
    endfunction

    assign opcode = dec_inst_i[31:26];
    assign rs     = dec_inst_i[25:21];
    assign rt     = dec_inst_i[20:16];
    assign rd     = dec_inst_i[15:11];
    assign funct  = dec_inst_i[5:0];
    assign imm    = dec_inst_i[15:0];

    assign rs_addr_o = rs;
    assign rt_addr_o = rt;
    assign rs_fwd    = fwd_operand(rs, rs_data_i);
    assign rt_fwd    = fwd_operand(rt, rt_data_i);

    always_comb begin
        alu_op   = ALU_ADD;
        mem_op   = MEM_NONE;
        dest     = rt;
        wr_en    = 1'b0;
        use_rs   = 1'b0;
        use_rt   = 1'b0;
        b_is_imm = 1'b1;
        imm_val  = {{16{imm[15]}}, imm};
        case (opcode)
            `MIPS_OP_SPECIAL: begin
                dest     = rd;
                b_is_imm = 1'b0;
                use_rs   = 1'b1;
                use_rt   = 1'b1;
                wr_en    = 1'b1;
                case (funct)
                    `MIPS_FN_ADDU: alu_op = ALU_ADD;
                    `MIPS_FN_SUBU: alu_op = ALU_SUB;
                    `MIPS_FN_AND:  alu_op = ALU_AND;
                    `MIPS_FN_OR:   alu_op = ALU_OR;
                    `MIPS_FN_XOR:  alu_op = ALU_XOR;
                    `MIPS_FN_SLT:  alu_op = ALU_SLT;
                    default: begin
                        use_rs = 1'b0;
                        use_rt = 1'b0;
                        wr_en  = 1'b0;
                    end
                endcase
            end
            `MIPS_OP_ADDIU: begin
                use_rs = 1'b1;
                wr_en  = 1'b1;
            end
            `MIPS_OP_ORI: begin
                alu_op  = ALU_OR;
                imm_val = {16'b0, imm};
                use_rs  = 1'b1;
                wr_en   = 1'b1;
            end
            `MIPS_OP_LUI: begin
                alu_op  = ALU_PASS_B;
                imm_val = {imm, 16'b0};
                wr_en   = 1'b1;
            end
            `MIPS_OP_LW: begin
                mem_op = MEM_LW;
                use_rs = 1'b1;
                wr_en  = 1'b1;
            end
            `MIPS_OP_SW: begin
                mem_op = MEM_SW;
                use_rs = 1'b1;
                use_rt = 1'b1;
            end
            `MIPS_OP_SB: begin
                mem_op = MEM_SB;
                use_rs = 1'b1;
                use_rt = 1'b1;
            end
            default: ;
        endcase
    end

    // load result only exists once the load reaches the result stage
    assign stall_o = (ex_o.mem_op == MEM_LW) && ex_o.wr_en &&
                     ((use_rs && ex_o.dest == rs) || (use_rt && ex_o.dest == rt));

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_o.alu_op <= ALU_ADD;
            ex_o.mem_op <= MEM_NONE;
            ex_o.wr_en  <= 1'b0;
        end else if (stall_o) begin
            ex_o.mem_op <= MEM_NONE;
            ex_o.wr_en  <= 1'b0;
        end else begin
            ex_o.alu_op <= alu_op;
            ex_o.mem_op <= mem_op;
            // r0 writes die here so no bypass ever matches r0
            ex_o.wr_en  <= wr_en && (dest != '0);
        end
    end

    always_ff @(posedge clk) begin
        ex_o.op_a       <= rs_fwd;
        ex_o.op_b       <= b_is_imm ? imm_val : rt_fwd;
        ex_o.store_data <= rt_fwd;
        ex_o.dest       <= dest;
    end

    // the bubble behind a stall can never be a load
    stall_single_a: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        stall_o |=> !stall_o
    );

endmodule

// ==== design/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage import mips_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    pipe_ex_if.sink    ex_i,
    output logic       ex_byp_en_o,
    output reg_addr_t  ex_byp_reg_o,
    output word_t      ex_byp_val_o,
    pipe_mem_if.source mem_o
);

    word_t alu_res;

    always_comb begin
        case (ex_i.alu_op)
            ALU_ADD:    alu_res = ex_i.op_a + ex_i.op_b;
            ALU_SUB:    alu_res = ex_i.op_a - ex_i.op_b;
            ALU_AND:    alu_res = ex_i.op_a & ex_i.op_b;
            ALU_OR:     alu_res = ex_i.op_a | ex_i.op_b;
            ALU_XOR:    alu_res = ex_i.op_a ^ ex_i.op_b;
            ALU_SLT:    alu_res = word_t'($signed(ex_i.op_a) < $signed(ex_i.op_b));
            ALU_PASS_B: alu_res = ex_i.op_b;
            default:    alu_res = ex_i.op_a + ex_i.op_b;
        endcase
    end

    // a load's ALU value is only its address
    assign ex_byp_en_o  = ex_i.wr_en && (ex_i.mem_op != MEM_LW) && (ex_i.dest != '0);
    assign ex_byp_reg_o = ex_i.dest;
    assign ex_byp_val_o = alu_res;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_o.mem_op <= MEM_NONE;
            mem_o.wr_en  <= 1'b0;
        end else begin
            mem_o.mem_op <= ex_i.mem_op;
            mem_o.wr_en  <= ex_i.wr_en;
        end
    end

    always_ff @(posedge clk) begin
        mem_o.alu_res    <= alu_res;
        mem_o.store_data <= ex_i.store_data;
        mem_o.dest       <= ex_i.dest;
    end

endmodule

// ==== design/fetch_unit.sv ====
`timescale 1ns/1ps
`include "mips_defs.svh"

module fetch_unit import mips_pkg::*; (
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  stall_i,
    output word_t inst_addr_o,
    input  inst_t inst_rdata_i,
    output inst_t dec_inst_o
);

    word_t pc_q;
    inst_t dec_inst_q;

    assign inst_addr_o = pc_q;
    assign dec_inst_o  = dec_inst_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q       <= `MIPS_RESET_PC;
            // all-zero word is sll r0, a no-op
            dec_inst_q <= '0;
        end else if (!stall_i) begin
            pc_q       <= pc_q + word_t'(4);
            dec_inst_q <= inst_rdata_i;
        end
    end

    // the instruction port has no byte lanes
    pc_aligned_a: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        pc_q[1:0] == 2'b00
    );

endmodule

// ==== design/mips_pkg.sv ====
`include "mips_defs.svh"

package mips_pkg;

    typedef logic [`MIPS_WORD_W-1:0]     word_t;
    typedef logic [`MIPS_WORD_W-1:0]     inst_t;
    typedef logic [`MIPS_REG_ADDR_W-1:0] reg_addr_t;

    // one enable per byte lane of a word
    typedef logic [`MIPS_WORD_W/8-1:0]   byte_en_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        // lui goes through here with the shifted immediate
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LW,
        MEM_SW,
        MEM_SB
    } mem_op_e;

endpackage

// ==== design/mips_top.sv ====
`timescale 1ns/1ps

module mips_top import mips_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,

    output word_t    inst_sram_addr_o,
    input  inst_t    inst_sram_rdata_i,

    output byte_en_t data_sram_wen_o,
    output word_t    data_sram_addr_o,
    output word_t    data_sram_wdata_o,
    input  word_t    data_sram_rdata_i
);

    logic      stall;
    inst_t     dec_inst;
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;

    logic      ex_byp_en;
    reg_addr_t ex_byp_reg;
    word_t     ex_byp_val;
    logic      res_byp_en;
    reg_addr_t res_byp_reg;
    word_t     res_byp_val;
    logic      wb_en;
    reg_addr_t wb_reg;
    word_t     wb_val;

    pipe_ex_if  ex_bus ();
    pipe_mem_if mem_bus ();

    fetch_unit u_fetch (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .stall_i      (stall),
        .inst_addr_o  (inst_sram_addr_o),
        .inst_rdata_i (inst_sram_rdata_i),
        .dec_inst_o   (dec_inst)
    );

    decode_stage u_decode (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .dec_inst_i    (dec_inst),
        .rs_addr_o     (rs_addr),
        .rt_addr_o     (rt_addr),
        .rs_data_i     (rs_data),
        .rt_data_i     (rt_data),
        .ex_byp_en_i   (ex_byp_en),
        .ex_byp_reg_i  (ex_byp_reg),
        .ex_byp_val_i  (ex_byp_val),
        .res_byp_en_i  (res_byp_en),
        .res_byp_reg_i (res_byp_reg),
        .res_byp_val_i (res_byp_val),
        .stall_o       (stall),
        .ex_o          (ex_bus.source)
    );

    reg_file u_reg_file (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .rs_addr_i (rs_addr),
        .rt_addr_i (rt_addr),
        .rs_data_o (rs_data),
        .rt_data_o (rt_data),
        .wb_en_i   (wb_en),
        .wb_reg_i  (wb_reg),
        .wb_val_i  (wb_val)
    );

    execute_stage u_execute (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .ex_i         (ex_bus.sink),
        .ex_byp_en_o  (ex_byp_en),
        .ex_byp_reg_o (ex_byp_reg),
        .ex_byp_val_o (ex_byp_val),
        .mem_o        (mem_bus.source)
    );

    result_stage u_result (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .mem_i         (mem_bus.sink),
        .data_wen_o    (data_sram_wen_o),
        .data_addr_o   (data_sram_addr_o),
        .data_wdata_o  (data_sram_wdata_o),
        .data_rdata_i  (data_sram_rdata_i),
        .res_byp_en_o  (res_byp_en),
        .res_byp_reg_o (res_byp_reg),
        .res_byp_val_o (res_byp_val),
        .wb_en_o       (wb_en),
        .wb_reg_o      (wb_reg),
        .wb_val_o      (wb_val)
    );

endmodule

// ==== design/pipe_if.sv ====
`timescale 1ns/1ps

// decode to execute register contents
interface pipe_ex_if import mips_pkg::*; ();

    alu_op_e   alu_op;
    word_t     op_a;
    word_t     op_b;
    word_t     store_data;
    mem_op_e   mem_op;
    reg_addr_t dest;
    logic      wr_en;

    modport source (
        output alu_op, op_a, op_b, store_data, mem_op, dest, wr_en
    );

    modport sink (
        input alu_op, op_a, op_b, store_data, mem_op, dest, wr_en
    );

endinterface

// execute to memory register contents
interface pipe_mem_if import mips_pkg::*; ();

    word_t     alu_res;
    word_t     store_data;
    mem_op_e   mem_op;
    reg_addr_t dest;
    logic      wr_en;

    modport source (
        output alu_res, store_data, mem_op, dest, wr_en
    );

    modport sink (
        input alu_res, store_data, mem_op, dest, wr_en
    );

endinterface

// ==== design/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import mips_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  reg_addr_t rs_addr_i,
    input  reg_addr_t rt_addr_i,
    output word_t     rs_data_o,
    output word_t     rt_data_o,
    input  logic      wb_en_i,
    input  reg_addr_t wb_reg_i,
    input  word_t     wb_val_i
);

    word_t regs [32];

    // same-cycle write is visible to decode
    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (wb_en_i && wb_reg_i == addr) begin
            return wb_val_i;
        end else begin
            return regs[addr];
        end
    endfunction

    assign rs_data_o = read_port(rs_addr_i);
    assign rt_data_o = read_port(rt_addr_i);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en_i && wb_reg_i != '0) begin
            regs[wb_reg_i] <= wb_val_i;
        end
    end

endmodule

// ==== design/result_stage.sv ====
`timescale 1ns/1ps

module result_stage import mips_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    pipe_mem_if.sink  mem_i,
    output byte_en_t  data_wen_o,
    output word_t     data_addr_o,
    output word_t     data_wdata_o,
    input  word_t     data_rdata_i,
    output logic      res_byp_en_o,
    output reg_addr_t res_byp_reg_o,
    output word_t     res_byp_val_o,
    output logic      wb_en_o,
    output reg_addr_t wb_reg_o,
    output word_t     wb_val_o
);

    word_t result;

    assign data_addr_o = {mem_i.alu_res[31:2], 2'b00};

    always_comb begin
        case (mem_i.mem_op)
            MEM_SW: begin
                data_wen_o   = 4'b1111;
                data_wdata_o = mem_i.store_data;
            end
            MEM_SB: begin
                // little endian, lane 0 holds address offset 0
                data_wen_o   = byte_en_t'(4'b0001 << mem_i.alu_res[1:0]);
                data_wdata_o = {4{mem_i.store_data[7:0]}};
            end
            default: begin
                data_wen_o   = '0;
                data_wdata_o = mem_i.store_data;
            end
        endcase
    end

    // read data is back in the same cycle
    assign result = (mem_i.mem_op == MEM_LW) ? data_rdata_i : mem_i.alu_res;

    assign res_byp_en_o  = mem_i.wr_en;
    assign res_byp_reg_o = mem_i.dest;
    assign res_byp_val_o = result;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_en_o <= 1'b0;
        end else begin
            wb_en_o <= mem_i.wr_en;
        end
    end

    always_ff @(posedge clk) begin
        wb_reg_o <= mem_i.dest;
        wb_val_o <= result;
    end

    no_stray_write_a: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (data_wen_o != '0) |-> (mem_i.mem_op inside {MEM_SW, MEM_SB}) && !mem_i.wr_en
    );

endmodule

// ==== files.f ====
+incdir+include
design/mips_pkg.sv
design/pipe_if.sv
design/fetch_unit.sv
design/decode_stage.sv
design/reg_file.sv
design/execute_stage.sv
design/result_stage.sv
design/mips_top.sv
verif/isa_model.sv
verif/tb_mips_top.sv

// ==== include/mips_defs.svh ====
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

`define MIPS_WORD_W      32
`define MIPS_REG_ADDR_W  5
`define MIPS_RESET_PC    32'h0000_0000

// primary opcode field
`define MIPS_OP_SPECIAL  6'h00
`define MIPS_OP_ADDIU    6'h09
`define MIPS_OP_ORI      6'h0d
`define MIPS_OP_LUI      6'h0f
`define MIPS_OP_LW       6'h23
`define MIPS_OP_SB       6'h28
`define MIPS_OP_SW       6'h2b

// function field of SPECIAL
`define MIPS_FN_ADDU     6'h21
`define MIPS_FN_SUBU     6'h23
`define MIPS_FN_AND      6'h24
`define MIPS_FN_OR       6'h25
`define MIPS_FN_XOR      6'h26
`define MIPS_FN_SLT      6'h2a

`endif

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -f sim.log
verilator --binary --timing --assert -f files.f --top-module tb_mips_top
./obj_dir/Vtb_mips_top | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== verif/isa_model.sv ====
`include "mips_defs.svh"

// in-order reference for the pipeline, one instruction per call
package isa_model;

    import mips_pkg::*;

    typedef struct packed {
        word_t    addr;
        word_t    data;
        byte_en_t wen;
    } store_t;

    word_t  gpr [32];
    word_t  data_mem [64];
    store_t store_q [$];

    function automatic inst_t r_type_word(input logic [5:0] funct, input reg_addr_t rs,
                                          input reg_addr_t rt, input reg_addr_t rd);
        return {`MIPS_OP_SPECIAL, rs, rt, rd, 5'b00000, funct};
    endfunction

    function automatic inst_t i_type_word(input logic [5:0] op, input reg_addr_t rs,
                                          input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic void execute_inst(input inst_t inst);
        logic [5:0]  op;
        logic [15:0] imm;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   dst;
        word_t       a;
        word_t       b;
        word_t       ea;
        word_t       res;
        logic        wr;
        store_t      st;
        op  = inst[31:26];
        rs  = inst[25:21];
        rt  = inst[20:16];
        imm = inst[15:0];
        a   = gpr[rs];
        b   = gpr[rt];
        ea  = a + {{16{imm[15]}}, imm};
        res = '0;
        wr  = 1'b1;
        dst = rt;
        case (op)
            `MIPS_OP_SPECIAL: begin
                dst = inst[15:11];
                case (inst[5:0])
                    `MIPS_FN_ADDU: res = a + b;
                    `MIPS_FN_SUBU: res = a - b;
                    `MIPS_FN_AND:  res = a & b;
                    `MIPS_FN_OR:   res = a | b;
                    `MIPS_FN_XOR:  res = a ^ b;
                    `MIPS_FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:       wr = 1'b0;
                endcase
            end
            `MIPS_OP_ADDIU: res = ea;
            `MIPS_OP_ORI:   res = a | {16'h0000, imm};
            `MIPS_OP_LUI:   res = {imm, 16'h0000};
            `MIPS_OP_LW:    res = data_mem[ea[7:2]];
            `MIPS_OP_SW: begin
                wr      = 1'b0;
                st.addr = {ea[31:2], 2'b00};
                st.data = b;
                st.wen  = 4'b1111;
                data_mem[ea[7:2]] = b;
                store_q.push_back(st);
            end
            `MIPS_OP_SB: begin
                wr      = 1'b0;
                st.addr = {ea[31:2], 2'b00};
                st.data = {4{b[7:0]}};
                st.wen  = '0;
                st.wen[ea[1:0]] = 1'b1;
                data_mem[ea[7:2]][8*ea[1:0] +: 8] = b[7:0];
                store_q.push_back(st);
            end
            default: wr = 1'b0;
        endcase
        if (wr && dst != '0) begin
            gpr[dst] = res;
        end
    endfunction

endpackage

// ==== verif/tb_mips_top.sv ====
`timescale 1ns/1ps
`include "mips_defs.svh"

module tb_mips_top import mips_pkg::*, isa_model::*; ();

    localparam int N_RAND          = 96;
    localparam int N_NOP           = 8;
    localparam int PROG_LEN        = N_RAND + N_NOP;
    localparam int WATCHDOG_CYCLES = 4 * PROG_LEN + 20;

    logic     clk;
    logic     rst_n_i;
    word_t    inst_sram_addr_o;
    inst_t    inst_sram_rdata_i;
    byte_en_t data_sram_wen_o;
    word_t    data_sram_addr_o;
    word_t    data_sram_wdata_o;
    word_t    data_sram_rdata_i;

    inst_t imem [128];
    word_t dmem [64];
    word_t prev_pc = `MIPS_RESET_PC;
    int    n_stores = 0;

    mips_top u_dut (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .inst_sram_addr_o  (inst_sram_addr_o),
        .inst_sram_rdata_i (inst_sram_rdata_i),
        .data_sram_wen_o   (data_sram_wen_o),
        .data_sram_addr_o  (data_sram_addr_o),
        .data_sram_wdata_o (data_sram_wdata_o),
        .data_sram_rdata_i (data_sram_rdata_i)
    );

    // both memories answer in the same cycle
    assign inst_sram_rdata_i = imem[inst_sram_addr_o[8:2]];
    assign data_sram_rdata_i = dmem[data_sram_addr_o[7:2]];

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_addr(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_data(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_wen(input string name, input byte_en_t exp, input byte_en_t act);
        if (exp !== act) begin
            $display("Mismatch in %s: expected %b, actual %b", name, exp, act);
            stop_with_failure();
        end
    endtask

    // registers 0 to 7 only so dependences stay dense
    function automatic reg_addr_t pick_reg();
        return reg_addr_t'($urandom % 8);
    endfunction

    function automatic inst_t random_inst();
        logic [5:0] fn;
        case ($urandom % 10)
            0, 1, 2, 3: begin
                case ($urandom % 6)
                    0:       fn = `MIPS_FN_ADDU;
                    1:       fn = `MIPS_FN_SUBU;
                    2:       fn = `MIPS_FN_AND;
                    3:       fn = `MIPS_FN_OR;
                    4:       fn = `MIPS_FN_XOR;
                    default: fn = `MIPS_FN_SLT;
                endcase
                return r_type_word(fn, pick_reg(), pick_reg(), pick_reg());
            end
            4: return i_type_word(`MIPS_OP_ADDIU, pick_reg(), pick_reg(), 16'($urandom));
            5: return i_type_word(`MIPS_OP_ORI, pick_reg(), pick_reg(), 16'($urandom));
            6: return i_type_word(`MIPS_OP_LUI, 5'd0, pick_reg(), 16'($urandom));
            7: return i_type_word(`MIPS_OP_LW, 5'd0, pick_reg(), 16'(4 * ($urandom % 64)));
            8: return i_type_word(`MIPS_OP_SW, 5'd0, pick_reg(), 16'(4 * ($urandom % 64)));
            default: return i_type_word(`MIPS_OP_SB, 5'd0, pick_reg(), 16'($urandom % 253));
        endcase
    endfunction

    always @(negedge clk) begin
        store_t exp;
        if (rst_n_i) begin
            // fetch either holds on a stall or steps one word
            if (inst_sram_addr_o != prev_pc && inst_sram_addr_o != prev_pc + 4) begin
                $display("fetch address moved from %h to %h instead of holding or stepping",
                         prev_pc, inst_sram_addr_o);
                stop_with_failure();
            end
            prev_pc = inst_sram_addr_o;
            if (data_sram_wen_o != '0) begin
                if (store_q.size() == 0) begin
                    $display("store to %h appeared with no store left in the model",
                             data_sram_addr_o);
                    stop_with_failure();
                end else begin
                    exp = store_q.pop_front();
                    check_addr($sformatf("store %0d address", n_stores), exp.addr,
                               data_sram_addr_o);
                    check_data($sformatf("store %0d data", n_stores), exp.data,
                               data_sram_wdata_o);
                    check_wen($sformatf("store %0d byte enables", n_stores), exp.wen,
                              data_sram_wen_o);
                    for (int b = 0; b < 4; b++) begin
                        if (data_sram_wen_o[b]) begin
                            dmem[data_sram_addr_o[7:2]][8*b +: 8] = data_sram_wdata_o[8*b +: 8];
                        end
                    end
                    n_stores++;
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles with %0d stores still pending",
                 WATCHDOG_CYCLES, store_q.size());
        stop_with_failure();
    end

    initial begin
        rst_n_i <= 1'b0;
        void'($urandom(31801));
        for (int i = 0; i < 128; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i]     = $urandom;
            data_mem[i] = dmem[i];
        end
        for (int i = 0; i < 32; i++) begin
            gpr[i] = '0;
        end
        // untouched tail stays zero and runs as no-ops
        for (int i = 0; i < N_RAND; i++) begin
            imem[i] = random_inst();
            execute_inst(imem[i]);
        end

        @(negedge clk);
        check_addr("reset pc", `MIPS_RESET_PC, inst_sram_addr_o);
        check_wen("reset write enables", '0, data_sram_wen_o);
        // second rising edge ends the two reset cycles
        @(posedge clk);
        rst_n_i <= 1'b1;

        while (inst_sram_addr_o != word_t'(PROG_LEN * 4)) begin
            @(negedge clk);
        end
        // let the store checks of this cycle finish first
        @(posedge clk);
        if (store_q.size() != 0) begin
            $display("%0d expected stores never reached the data port", store_q.size());
            stop_with_failure();
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule
